// File: verilog/issue_pkg.sv
package issue_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN   = 32;
    localparam int INST_W = 32;
    localparam int REG_W  = 5;
    localparam int KIND_W = 4;
    localparam int IMM_W  = 13;

    // Field positions in the raw instruction word
    localparam int OPC_LSB = 28;
    localparam int RD_LSB  = 23;
    localparam int RS1_LSB = 18;
    localparam int RS2_LSB = 13;

    ////////////////////////////////////////////////////////////
    // Instruction kind, straight from opcode bits 31..28
    ////////////////////////////////////////////////////////////

    typedef enum logic [KIND_W-1:0] {
        KIND_ALU    = 4'd0,
        KIND_MUL    = 4'd1,
        KIND_DIV    = 4'd2,
        KIND_LOAD   = 4'd3,
        KIND_STORE  = 4'd4,
        KIND_BRANCH = 4'd5,
        KIND_NOP    = 4'd6
    } inst_kind_e;

    // Decoded instruction as it travels through queue and dispatch
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        inst_kind_e        kind;
        logic [REG_W-1:0]  rd;
        logic              rf_we;
        logic [REG_W-1:0]  raddr1;
        logic [REG_W-1:0]  raddr2;
        logic [XLEN-1:0]   imm;
    } inst_set_t;

endpackage

// File: verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [issue_pkg::INST_W-1:0] i_inst,
    input  logic [issue_pkg::XLEN-1:0]   i_pc,
    input  logic                         i_push,
    output issue_pkg::inst_set_t         o_set
);

    logic [issue_pkg::KIND_W-1:0] opcode;
    logic [issue_pkg::REG_W-1:0]  f_rd;
    logic [issue_pkg::REG_W-1:0]  f_rs1;
    logic [issue_pkg::REG_W-1:0]  f_rs2;
    issue_pkg::inst_kind_e        kind;

    assign opcode = i_inst[issue_pkg::OPC_LSB +: issue_pkg::KIND_W];
    assign f_rd   = i_inst[issue_pkg::RD_LSB  +: issue_pkg::REG_W];
    assign f_rs1  = i_inst[issue_pkg::RS1_LSB +: issue_pkg::REG_W];
    assign f_rs2  = i_inst[issue_pkg::RS2_LSB +: issue_pkg::REG_W];

    // Unused opcodes fall back to NOP
    always_comb begin
        case (opcode)
            issue_pkg::KIND_ALU:    kind = issue_pkg::KIND_ALU;
            issue_pkg::KIND_MUL:    kind = issue_pkg::KIND_MUL;
            issue_pkg::KIND_DIV:    kind = issue_pkg::KIND_DIV;
            issue_pkg::KIND_LOAD:   kind = issue_pkg::KIND_LOAD;
            issue_pkg::KIND_STORE:  kind = issue_pkg::KIND_STORE;
            issue_pkg::KIND_BRANCH: kind = issue_pkg::KIND_BRANCH;
            default:                kind = issue_pkg::KIND_NOP;
        endcase
    end

    always_comb begin
        o_set        = '0;
        o_set.valid  = i_push;
        o_set.pc     = i_pc;
        o_set.kind   = kind;
        o_set.imm    = {{(issue_pkg::XLEN - issue_pkg::IMM_W){i_inst[issue_pkg::IMM_W-1]}},
                        i_inst[issue_pkg::IMM_W-1:0]};

        case (kind)
            issue_pkg::KIND_ALU, issue_pkg::KIND_MUL, issue_pkg::KIND_DIV: begin
                o_set.rd     = f_rd;
                o_set.raddr1 = f_rs1;
                o_set.raddr2 = f_rs2;
            end
            issue_pkg::KIND_LOAD: begin
                // Base register only
                o_set.rd     = f_rd;
                o_set.raddr1 = f_rs1;
            end
            issue_pkg::KIND_STORE, issue_pkg::KIND_BRANCH: begin
                o_set.raddr1 = f_rs1;
                o_set.raddr2 = f_rs2;
            end
            default: begin
                // NOP reads and writes nothing
            end
        endcase

        // Writes to x0 are discarded
        o_set.rf_we = (o_set.rd != '0);
    end

endmodule

// File: verilog/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  issue_pkg::inst_set_t i_set,
    input  logic [1:0]           i_pop_num,
    output issue_pkg::inst_set_t o_head1,
    output issue_pkg::inst_set_t o_head2,
    output logic                 o_full
);

    // Depth is a power of two, so the pointers wrap on their own
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    issue_pkg::inst_set_t mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] rd_ptr_p1;
    logic [CNT_W-1:0] count;
    logic             push;

    assign o_full    = (count == CNT_W'(QUEUE_DEPTH));
    assign push      = i_set.valid && !o_full && !i_flush;
    assign rd_ptr_p1 = rd_ptr + PTR_W'(1);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_set;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            rd_ptr <= rd_ptr + PTR_W'(i_pop_num);
            count  <= count + CNT_W'(push) - CNT_W'(i_pop_num);
        end
    end

    ////////////////////////////////////////////////////////////
    // Oldest two entries, valid taken from occupancy
    ////////////////////////////////////////////////////////////

    always_comb begin
        o_head1       = mem[rd_ptr];
        o_head1.valid = (count >= CNT_W'(1));
        o_head2       = mem[rd_ptr_p1];
        o_head2.valid = (count >= CNT_W'(2));
    end

endmodule

// File: verilog/issue_dispatch.sv
`timescale 1ns/1ps

module issue_dispatch (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic                 i_stall,
    input  issue_pkg::inst_set_t i_set1,
    input  issue_pkg::inst_set_t i_set2,
    output issue_pkg::inst_set_t o_set1,
    output issue_pkg::inst_set_t o_set2,
    output logic [1:0]           o_issue_num
);

    // Load issued in the previous cycle
    logic                        last_ld;
    logic [issue_pkg::REG_W-1:0] ld_rd;

    logic lock1;
    logic lock2;
    logic alu1;
    logic both_br;
    logic raw;
    logic ld1_issued;
    logic ld2_issued;

    ////////////////////////////////////////////////////////////
    // Hazard terms
    ////////////////////////////////////////////////////////////

    // Load-use interlock per slot
    assign lock1 = last_ld && (ld_rd != '0) &&
                   ((ld_rd == i_set1.raddr1) || (ld_rd == i_set1.raddr2));
    assign lock2 = last_ld && (ld_rd != '0) &&
                   ((ld_rd == i_set2.raddr1) || (ld_rd == i_set2.raddr2));

    assign alu1    = (i_set1.kind == issue_pkg::KIND_ALU);
    assign both_br = (i_set1.kind == issue_pkg::KIND_BRANCH) &&
                     (i_set2.kind == issue_pkg::KIND_BRANCH);

    // Younger reads what the older one writes
    assign raw = i_set1.rf_we &&
                 ((i_set1.rd == i_set2.raddr1) || (i_set1.rd == i_set2.raddr2));

    ////////////////////////////////////////////////////////////
    // Issue decision, first match wins
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (i_flush || i_stall) begin
            o_issue_num = 2'd0;
        end else if (!i_set1.valid) begin
            o_issue_num = 2'd0;
        end else if (lock1) begin
            o_issue_num = 2'd0;
        end else if (!i_set2.valid) begin
            o_issue_num = 2'd1;
        end else if (lock2) begin
            o_issue_num = 2'd1;
        end else if (!alu1) begin
            o_issue_num = 2'd1;
        end else if (both_br) begin
            o_issue_num = 2'd1;
        end else if (raw) begin
            o_issue_num = 2'd1;
        end else begin
            o_issue_num = 2'd2;
        end
    end

    // Payload passes through, only valid is rewritten
    always_comb begin
        o_set1       = i_set1;
        o_set1.valid = (o_issue_num != 2'd0);
        o_set2       = i_set2;
        o_set2.valid = (o_issue_num == 2'd2);
    end

    ////////////////////////////////////////////////////////////
    // Last-load tracking
    ////////////////////////////////////////////////////////////

    assign ld1_issued = o_set1.valid && (i_set1.kind == issue_pkg::KIND_LOAD);
    assign ld2_issued = o_set2.valid && (i_set2.kind == issue_pkg::KIND_LOAD);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            last_ld <= 1'b0;
        end else begin
            last_ld <= ld1_issued || ld2_issued;
        end
    end

    // Slot 2 is the younger one when both are loads
    always_ff @(posedge clk) begin
        if (ld2_issued) begin
            ld_rd <= i_set2.rd;
        end else if (ld1_issued) begin
            ld_rd <= i_set1.rd;
        end
    end

endmodule

// File: verilog/issue_stage.sv
`timescale 1ns/1ps

module issue_stage #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         i_rst_n,
    input  logic [issue_pkg::INST_W-1:0] i_inst,
    input  logic [issue_pkg::XLEN-1:0]   i_pc,
    input  logic                         i_push,
    input  logic                         i_flush,
    input  logic                         i_stall,
    output logic                         o_full,
    output issue_pkg::inst_set_t         o_slot1,
    output issue_pkg::inst_set_t         o_slot2,
    output logic [1:0]                   o_issue_num
);

    issue_pkg::inst_set_t dec_set;
    issue_pkg::inst_set_t head1;
    issue_pkg::inst_set_t head2;

    inst_decoder u_inst_decoder (
        .i_inst (i_inst),
        .i_pc   (i_pc),
        .i_push (i_push),
        .o_set  (dec_set)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_inst_queue (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_flush   (i_flush),
        .i_set     (dec_set),
        .i_pop_num (o_issue_num),
        .o_head1   (head1),
        .o_head2   (head2),
        .o_full    (o_full)
    );

    // Issue count doubles as the queue pop count
    issue_dispatch u_issue_dispatch (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_stall     (i_stall),
        .i_set1      (head1),
        .i_set2      (head2),
        .o_set1      (o_slot1),
        .o_set2      (o_slot2),
        .o_issue_num (o_issue_num)
    );

endmodule

// File: tests/issue_stage_assert.sv
`timescale 1ns/1ps

module issue_stage_assert (
    input logic                 clk,
    input logic                 i_rst_n,
    input logic                 i_flush,
    input logic                 i_stall,
    input issue_pkg::inst_set_t i_head1,
    input issue_pkg::inst_set_t i_head2,
    input issue_pkg::inst_set_t i_slot1,
    input logic [1:0]           i_issue_num
);

    // A stall pops nothing, so the oldest entry stays in front
    a_stall_keeps_head: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_stall && !i_flush && i_head1.valid) |=>
            (i_head1.valid && (i_head1.pc == $past(i_head1.pc))))
        else $error("queue head changed across a stall");

    a_flush_empties: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_flush |=> !i_head1.valid)
        else $error("queue not empty after a flush");

    // Single issue with two present brings the second entry to the front
    a_single_pop_advances: assert property (@(posedge clk) disable iff (!i_rst_n)
        ((i_issue_num == 2'd1) && i_head2.valid) |=>
            (i_head1.valid && (i_head1.pc == $past(i_head2.pc))))
        else $error("queue head did not advance by one after a single issue");

    // Consumer of a just-issued load waits a cycle
    a_load_use_held: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_slot1.valid && (i_slot1.kind == issue_pkg::KIND_LOAD) && (i_slot1.rd != '0)) |=>
            !(i_slot1.valid && ((i_slot1.raddr1 == $past(i_slot1.rd)) ||
                                (i_slot1.raddr2 == $past(i_slot1.rd)))))
        else $error("load result used in the cycle right after the load issued");

endmodule

bind issue_dispatch issue_stage_assert u_issue_stage_assert (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_flush     (i_flush),
    .i_stall     (i_stall),
    .i_head1     (i_set1),
    .i_head2     (i_set2),
    .i_slot1     (o_set1),
    .i_issue_num (o_issue_num)
);

// File: tests/tb_issue_stage.sv
`timescale 1ns/1ps

module tb_issue_stage;

    localparam int QUEUE_DEPTH    = 8;
    localparam int SEED           = 7314;
    localparam int RESET_CYCLES   = 4;
    localparam int IDLE_CYCLES    = 3;
    localparam int NUM_CYCLES     = 2000;
    // Reset, idle lead-in and the random run, with margin on top
    localparam int TIMEOUT_CYCLES = 2500;

    // Model view of one decoded instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  kind;
        logic [4:0]  rd;
        logic        we;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
    } model_inst_t;

    logic                 clk;
    logic                 i_rst_n;
    logic [31:0]          i_inst;
    logic [31:0]          i_pc;
    logic                 i_push;
    logic                 i_flush;
    logic                 i_stall;
    logic                 o_full;
    issue_pkg::inst_set_t o_slot1;
    issue_pkg::inst_set_t o_slot2;
    logic [1:0]           o_issue_num;

    model_inst_t mq[$];
    logic        last_ld_m;
    logic [4:0]  ld_rd_m;
    logic        checking;
    logic [31:0] next_pc;
    int          cycle_cnt = 0;
    int          n_checks  = 0;
    int          n_errors  = 0;
    int          n_dual    = 0;
    int          n_locks   = 0;
    int          n_full    = 0;

    issue_stage #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_issue_stage (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_inst      (i_inst),
        .i_pc        (i_pc),
        .i_push      (i_push),
        .i_flush     (i_flush),
        .i_stall     (i_stall),
        .o_full      (o_full),
        .o_slot1     (o_slot1),
        .o_slot2     (o_slot2),
        .o_issue_num (o_issue_num)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////////////////////////

    // Registers from 0..3 keep hazards frequent
    function automatic logic [31:0] make_inst(input bit alu_only);
        logic [3:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] imm;
        if (alu_only) begin
            op = 4'(issue_pkg::KIND_ALU);
        end else begin
            op = 4'($urandom % 8);
        end
        rd  = 5'($urandom % 4);
        rs1 = 5'($urandom % 4);
        rs2 = 5'($urandom % 4);
        imm = 13'($urandom);
        return {op, rd, rs1, rs2, imm};
    endfunction

    function automatic model_inst_t decode_raw(input logic [31:0] inst, input logic [31:0] pc);
        model_inst_t m;
        m     = '0;
        m.pc  = pc;
        m.imm = {{19{inst[12]}}, inst[12:0]};
        // Codes above BRANCH are NOPs
        if (inst[31:28] > 4'd5) begin
            m.kind = 4'(issue_pkg::KIND_NOP);
        end else begin
            m.kind = inst[31:28];
        end
        case (m.kind)
            issue_pkg::KIND_ALU, issue_pkg::KIND_MUL, issue_pkg::KIND_DIV: begin
                m.rd  = inst[27:23];
                m.rs1 = inst[22:18];
                m.rs2 = inst[17:13];
                m.we  = (m.rd != 5'd0);
            end
            issue_pkg::KIND_LOAD: begin
                m.rd  = inst[27:23];
                m.rs1 = inst[22:18];
                m.we  = (m.rd != 5'd0);
            end
            issue_pkg::KIND_STORE, issue_pkg::KIND_BRANCH: begin
                m.rs1 = inst[22:18];
                m.rs2 = inst[17:13];
            end
            default: begin
            end
        endcase
        return m;
    endfunction

    function automatic logic is_interlocked(input model_inst_t s);
        return last_ld_m && (ld_rd_m != 5'd0) && ((ld_rd_m == s.rs1) || (ld_rd_m == s.rs2));
    endfunction

    function automatic logic [1:0] pick_issue_count(input int have, input model_inst_t s1,
                                                    input model_inst_t s2, input logic flush,
                                                    input logic stall);
        logic raw;
        raw = s1.we && ((s1.rd == s2.rs1) || (s1.rd == s2.rs2));
        if (flush || stall) return 2'd0;
        if (have == 0) return 2'd0;
        if (is_interlocked(s1)) return 2'd0;
        if (have == 1) return 2'd1;
        if (is_interlocked(s2)) return 2'd1;
        if (s1.kind != issue_pkg::KIND_ALU) return 2'd1;
        if (s1.kind == issue_pkg::KIND_BRANCH && s2.kind == issue_pkg::KIND_BRANCH) return 2'd1;
        if (raw) return 2'd1;
        return 2'd2;
    endfunction

    task automatic note_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        $display("Fail %s expected 0x%0h actual 0x%0h at cycle %0d",
                 name, exp_val, act_val, cycle_cnt);
        n_errors++;
    endtask

    // Every payload field of an issued slot against the model entry
    task automatic check_slot(input string name, input model_inst_t exp_s,
                              input issue_pkg::inst_set_t act_s);
        if (act_s.pc !== exp_s.pc)
            note_mismatch({name, "_pc"}, exp_s.pc, act_s.pc);
        if (act_s.kind !== exp_s.kind)
            note_mismatch({name, "_kind"}, 32'(exp_s.kind), 32'(act_s.kind));
        if (act_s.rd !== exp_s.rd)
            note_mismatch({name, "_rd"}, 32'(exp_s.rd), 32'(act_s.rd));
        if (act_s.rf_we !== exp_s.we)
            note_mismatch({name, "_rf_we"}, 32'(exp_s.we), 32'(act_s.rf_we));
        if (act_s.raddr1 !== exp_s.rs1)
            note_mismatch({name, "_raddr1"}, 32'(exp_s.rs1), 32'(act_s.raddr1));
        if (act_s.raddr2 !== exp_s.rs2)
            note_mismatch({name, "_raddr2"}, 32'(exp_s.rs2), 32'(act_s.raddr2));
        if (act_s.imm !== exp_s.imm)
            note_mismatch({name, "_imm"}, exp_s.imm, act_s.imm);
    endtask

    // Heavy stall window to fill the queue, then an ALU-only window for pairs
    task automatic drive_cycle(input int cyc);
        int stall_pct;
        bit alu_only;
        stall_pct = (cyc >= 1000 && cyc < 1300) ? 75 : 10;
        alu_only  = (cyc >= 1500 && cyc < 1700);
        i_stall <= (($urandom % 100) < stall_pct);
        i_flush <= (($urandom % 100) < 2);
        if ((($urandom % 100) < 85) && (mq.size() < QUEUE_DEPTH)) begin
            i_push  <= 1'b1;
            i_inst  <= make_inst(alu_only);
            i_pc    <= next_pc;
            next_pc = next_pc + 32'd4;
        end else begin
            i_push <= 1'b0;
            i_inst <= $urandom;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare at the falling edge, then step the model
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        model_inst_t s1;
        model_inst_t s2;
        int          have;
        logic [1:0]  exp_num;
        logic        push_ok;
        logic        new_ld;
        if (checking) begin
            have    = mq.size();
            s1      = (have > 0) ? mq[0] : '0;
            s2      = (have > 1) ? mq[1] : '0;
            exp_num = pick_issue_count(have, s1, s2, i_flush, i_stall);
            n_checks++;

            if (o_issue_num !== exp_num)
                note_mismatch("issue_num", 32'(exp_num), 32'(o_issue_num));
            if (o_slot1.valid !== (exp_num != 2'd0))
                note_mismatch("slot1_valid", 32'(exp_num != 2'd0), 32'(o_slot1.valid));
            if (o_slot2.valid !== (exp_num == 2'd2))
                note_mismatch("slot2_valid", 32'(exp_num == 2'd2), 32'(o_slot2.valid));
            if (o_full !== (have == QUEUE_DEPTH))
                note_mismatch("full", 32'(have == QUEUE_DEPTH), 32'(o_full));
            if (exp_num != 2'd0) begin
                check_slot("slot1", s1, o_slot1);
            end
            if (exp_num == 2'd2) begin
                check_slot("slot2", s2, o_slot2);
            end

            if (exp_num == 2'd2) n_dual++;
            if (!i_flush && !i_stall && have > 0 && is_interlocked(s1)) n_locks++;
            if (have == QUEUE_DEPTH) n_full++;

            // State after the coming edge
            push_ok = i_push && !i_flush && (have < QUEUE_DEPTH);
            new_ld  = 1'b0;
            if (exp_num != 2'd0 && s1.kind == issue_pkg::KIND_LOAD) begin
                new_ld  = 1'b1;
                ld_rd_m = s1.rd;
            end
            if (exp_num == 2'd2 && s2.kind == issue_pkg::KIND_LOAD) begin
                new_ld  = 1'b1;
                ld_rd_m = s2.rd;
            end
            last_ld_m = new_ld;
            for (int k = 0; k < int'(exp_num); k++) begin
                void'(mq.pop_front());
            end
            if (i_flush) begin
                mq.delete();
            end else if (push_ok) begin
                mq.push_back(decode_raw(i_inst, i_pc));
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        i_rst_n   = 1'b0;
        i_inst    = '0;
        i_pc      = '0;
        i_push    = 1'b0;
        i_flush   = 1'b0;
        i_stall   = 1'b0;
        checking  = 1'b0;
        last_ld_m = 1'b0;
        ld_rd_m   = '0;
        next_pc   = 32'h0000_1000;

        repeat (RESET_CYCLES) @(posedge clk);
        i_rst_n <= 1'b1;
        checking = 1'b1;

        // Quiet lead-in, outputs must stay inactive
        repeat (IDLE_CYCLES) @(posedge clk);

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            drive_cycle(cyc);
        end

        @(posedge clk);
        checking = 1'b0;
        i_push  <= 1'b0;
        i_flush <= 1'b0;
        i_stall <= 1'b0;

        if (n_dual == 0) begin
            $display("No dual issue happened during the run");
            n_errors++;
        end
        if (n_locks == 0) begin
            $display("No load-use interlock happened during the run");
            n_errors++;
        end
        if (n_full == 0) begin
            $display("The queue never became full during the run");
            n_errors++;
        end

        $display("Checks %0d, errors %0d, dual issues %0d, interlocks %0d, full cycles %0d",
                 n_checks, n_errors, n_dual, n_locks, n_full);
        if (n_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
verilog/issue_pkg.sv
verilog/inst_decoder.sv
verilog/inst_queue.sv
verilog/issue_dispatch.sv
verilog/issue_stage.sv
tests/issue_stage_assert.sv
tests/tb_issue_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_issue_stage \
    -Mdir "$BUILD_DIR" -o sim_issue_stage \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_issue_stage" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation run returned status $sim_status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
